// File: sim/pss_detector_ctrl_tb.sv
module pss_detector_ctrl_tb;

    import pss_regmap_pkg::*;

    localparam int ADDR_W        = 11;
    localparam int DRIVE_DLY     = 2;
    localparam int RESET_CYCLES  = 16;
    localparam int TRANS_TIMEOUT = 20;
    localparam int N_PEAKS       = 64;
    localparam int MAX_HOLD      = 10;
    // rough count of axi transactions over all tests
    localparam int N_TRANSACTIONS = 40;
    localparam int TRANS_CYCLES   = 8;
    localparam int MAX_CYCLES     = RESET_CYCLES + N_TRANSACTIONS * (TRANS_CYCLES + MAX_HOLD)
                                    + 2 * N_PEAKS + 50;
    // two to the power of CORR_DW/2 with the default width of 32
    localparam logic [31:0] EXP_NOISE_LIMIT = 32'h0001_0000;

    logic              clk;
    logic              reset_n;
    logic [ADDR_W-1:0] s_axi_awaddr;
    logic              s_axi_awvalid;
    logic              s_axi_awready;
    logic [31:0]       s_axi_wdata;
    logic              s_axi_wvalid;
    logic              s_axi_wready;
    logic [1:0]        s_axi_bresp;
    logic              s_axi_bvalid;
    logic              s_axi_bready;
    logic [ADDR_W-1:0] s_axi_araddr;
    logic              s_axi_arvalid;
    logic              s_axi_arready;
    logic [31:0]       s_axi_rdata;
    logic [1:0]        s_axi_rresp;
    logic              s_axi_rvalid;
    logic              s_axi_rready;
    logic              peak_valid;
    logic [1:0]        peak_nid;
    logic [1:0]        mode;
    logic signed [31:0] cfo_angle;
    logic [31:0]       peak_fifo_level;
    logic [31:0]       data_fifo_level;
    logic              cfo_mode;
    logic [31:0]       noise_limit;
    logic [7:0]        detection_shift;

    int seed = 32'hb655_e2ba;
    int error_count = 0;
    int timeout_count = 0;
    int check_count = 0;
    int cycle_count = 0;

    tb_clock_gen #(
        .PERIOD      (20),
        .RESET_CYCLES(RESET_CYCLES),
        .DRIVE_DLY   (DRIVE_DLY)
    ) tb_clock_gen_i (
        .clk_o   (clk),
        .reset_no(reset_n)
    );

    pss_detector_ctrl_top pss_detector_ctrl_top_i (
        .clk_i            (clk),
        .reset_ni         (reset_n),
        .s_axi_awaddr_i   (s_axi_awaddr),
        .s_axi_awvalid_i  (s_axi_awvalid),
        .s_axi_awready_o  (s_axi_awready),
        .s_axi_wdata_i    (s_axi_wdata),
        .s_axi_wvalid_i   (s_axi_wvalid),
        .s_axi_wready_o   (s_axi_wready),
        .s_axi_bresp_o    (s_axi_bresp),
        .s_axi_bvalid_o   (s_axi_bvalid),
        .s_axi_bready_i   (s_axi_bready),
        .s_axi_araddr_i   (s_axi_araddr),
        .s_axi_arvalid_i  (s_axi_arvalid),
        .s_axi_arready_o  (s_axi_arready),
        .s_axi_rdata_o    (s_axi_rdata),
        .s_axi_rresp_o    (s_axi_rresp),
        .s_axi_rvalid_o   (s_axi_rvalid),
        .s_axi_rready_i   (s_axi_rready),
        .peak_valid_i     (peak_valid),
        .peak_nid_i       (peak_nid),
        .mode_i           (mode),
        .cfo_angle_i      (cfo_angle),
        .peak_fifo_level_i(peak_fifo_level),
        .data_fifo_level_i(data_fifo_level),
        .cfo_mode_o       (cfo_mode),
        .noise_limit_o    (noise_limit),
        .detection_shift_o(detection_shift)
    );

    // whole-run watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("run did not finish within %0d cycles, stopping", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [ADDR_W-1:0] word_addr(input int idx);
        return ADDR_W'(idx * 4);
    endfunction

    task automatic compare_word(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic compare_resp(input string name, input logic [1:0] actual,
                                input logic [1:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s is %b, expected %b", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic compare_count(input string name, input peak_count_t actual,
                                 input peak_count_t expected);
        check_count++;
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what, input int idx);
        $display("timeout at time %0t: no %s for register index %0d", $time, what, idx);
        timeout_count++;
    endtask

    // one write, bready held low for hold_cycles once bvalid is up
    task automatic axi_write(input int idx, input logic [31:0] data, input int hold_cycles);
        int   waited;
        logic seen;
        @(posedge clk);
        #DRIVE_DLY;
        s_axi_awaddr  = word_addr(idx);
        s_axi_awvalid = 1'b1;
        s_axi_wdata   = data;
        s_axi_wvalid  = 1'b1;
        s_axi_bready  = 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            seen = s_axi_awready && s_axi_wready;
        end while (!seen && waited < TRANS_TIMEOUT);
        #DRIVE_DLY;
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        if (!seen) begin
            report_timeout("awready and wready", idx);
            return;
        end
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            seen = s_axi_bvalid;
        end while (!seen && waited < TRANS_TIMEOUT);
        if (!seen) begin
            report_timeout("bvalid", idx);
            return;
        end
        compare_resp("s_axi_bresp", s_axi_bresp, AXI_RESP_OKAY);
        repeat (hold_cycles) begin
            @(posedge clk);
            if (s_axi_bvalid !== 1'b1) begin
                $display("FAILED at time %0t: s_axi_bvalid is %b, expected 1",
                         $time, s_axi_bvalid);
                error_count++;
            end
        end
        #DRIVE_DLY;
        s_axi_bready = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        s_axi_bready = 1'b0;
    endtask

    // one read, rready held low for hold_cycles once rvalid is up
    task automatic axi_read(input int idx, output logic [31:0] data, input int hold_cycles);
        int   waited;
        logic seen;
        data = 'x;
        @(posedge clk);
        #DRIVE_DLY;
        s_axi_araddr  = word_addr(idx);
        s_axi_arvalid = 1'b1;
        s_axi_rready  = 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            seen = s_axi_arready;
        end while (!seen && waited < TRANS_TIMEOUT);
        #DRIVE_DLY;
        s_axi_arvalid = 1'b0;
        if (!seen) begin
            report_timeout("arready", idx);
            return;
        end
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            seen = s_axi_rvalid;
        end while (!seen && waited < TRANS_TIMEOUT);
        if (!seen) begin
            report_timeout("rvalid", idx);
            return;
        end
        data = s_axi_rdata;
        compare_resp("s_axi_rresp", s_axi_rresp, AXI_RESP_OKAY);
        repeat (hold_cycles) begin
            @(posedge clk);
            if (s_axi_rvalid !== 1'b1) begin
                $display("FAILED at time %0t: s_axi_rvalid is %b, expected 1",
                         $time, s_axi_rvalid);
                error_count++;
            end
            compare_word("s_axi_rdata while held", s_axi_rdata, data);
        end
        #DRIVE_DLY;
        s_axi_rready = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        s_axi_rready = 1'b0;
    endtask

    task automatic read_check(input int idx, input logic [31:0] expected, input string name);
        logic [31:0] data;
        axi_read(idx, data, 0);
        compare_word(name, data, expected);
    endtask

    task automatic reset_state_and_id();
        compare_word("noise_limit_o", noise_limit, EXP_NOISE_LIMIT);
        compare_word("detection_shift_o", {24'd0, detection_shift}, 32'd3);
        compare_word("cfo_mode_o", {31'd0, cfo_mode}, 32'd0);
        read_check(REG_VERSION, PCORE_VERSION, "version register");
        read_check(REG_ID, 32'd0, "id register");
        read_check(REG_MAGIC, PSSD_MAGIC, "magic register");
        read_check(REG_FILLER, FILLER_WORD, "filler register");
    endtask

    task automatic tuning_register_writes();
        logic [31:0] w;
        w = $random(seed);
        axi_write(REG_SCRATCH, w, 0);
        read_check(REG_SCRATCH, w, "scratch register");
        w = $random(seed);
        axi_write(REG_NOISE_LIMIT, w, 0);
        compare_word("noise_limit_o", noise_limit, w);
        read_check(REG_NOISE_LIMIT, w, "noise limit register");
        w = $random(seed);
        axi_write(REG_DET_SHIFT, w, 0);
        // only the low byte survives
        compare_word("detection_shift_o", {24'd0, detection_shift}, {24'd0, w[7:0]});
        read_check(REG_DET_SHIFT, {24'd0, w[7:0]}, "detection shift register");
        w = $random(seed) | 32'd1;
        axi_write(REG_CFO_MODE, w, 0);
        compare_word("cfo_mode_o", {31'd0, cfo_mode}, 32'd1);
        read_check(REG_CFO_MODE, 32'd1, "cfo mode register");
    endtask

    task automatic live_status_reads();
        @(posedge clk);
        #DRIVE_DLY;
        mode            = 2'($random(seed));
        cfo_angle       = $random(seed);
        peak_fifo_level = $random(seed);
        data_fifo_level = $random(seed);
        read_check(REG_MODE, {30'd0, mode}, "mode register");
        read_check(REG_CFO_ANGLE, cfo_angle, "cfo angle register");
        read_check(REG_PEAK_FIFO_LVL, peak_fifo_level, "peak fifo level register");
        read_check(REG_DATA_FIFO_LVL, data_fifo_level, "data fifo level register");
        read_check(REG_CNT_CLEAR, 32'd0, "counter clear register");
        read_check(16, 32'd0, "unmapped index 16");
        read_check(200, 32'd0, "unmapped index 200");
        read_check(511, 32'd0, "unmapped index 511");
    endtask

    task automatic peak_counter_sequence();
        peak_count_t expected [N_NID];
        logic [31:0] data;
        int          nid;
        for (int i = 0; i < N_NID; i++) begin
            expected[i] = '0;
        end
        // random strobes with gaps, model counts alongside
        repeat (N_PEAKS) begin
            @(posedge clk);
            #DRIVE_DLY;
            nid        = {$random(seed)} % N_NID;
            peak_valid = ({$random(seed)} % 4) != 0;
            peak_nid   = nid[1:0];
            if (peak_valid) begin
                expected[nid] = expected[nid] + 1;
            end
        end
        @(posedge clk);
        #DRIVE_DLY;
        peak_valid = 1'b0;
        for (int i = 0; i < N_NID; i++) begin
            axi_read(REG_PEAK_CNT_0 + i, data, 0);
            compare_count($sformatf("peak count of N_id %0d", i), data, expected[i]);
        end
        axi_write(REG_CNT_CLEAR, 32'd1, 0);
        for (int i = 0; i < N_NID; i++) begin
            axi_read(REG_PEAK_CNT_0 + i, data, 0);
            compare_count($sformatf("cleared peak count of N_id %0d", i), data, '0);
        end
    endtask

    task automatic back_pressure_holds();
        logic [31:0] w;
        logic [31:0] r;
        int          hold;
        repeat (3) begin
            w    = $random(seed);
            hold = 3 + {$random(seed)} % (MAX_HOLD - 2);
            axi_write(REG_SCRATCH, w, hold);
            hold = 3 + {$random(seed)} % (MAX_HOLD - 2);
            axi_read(REG_SCRATCH, r, hold);
            compare_word("scratch read under back-pressure", r, w);
        end
    endtask

    initial begin
        s_axi_awaddr    = '0;
        s_axi_awvalid   = 1'b0;
        s_axi_wdata     = '0;
        s_axi_wvalid    = 1'b0;
        s_axi_bready    = 1'b0;
        s_axi_araddr    = '0;
        s_axi_arvalid   = 1'b0;
        s_axi_rready    = 1'b0;
        peak_valid      = 1'b0;
        peak_nid        = '0;
        mode            = '0;
        cfo_angle       = '0;
        peak_fifo_level = '0;
        data_fifo_level = '0;
        wait (reset_n === 1'b1);
        repeat (2) @(posedge clk);
        reset_state_and_id();
        tuning_register_writes();
        live_status_reads();
        peak_counter_sequence();
        back_pressure_holds();
        $display("summary: %0d checks, %0d mismatches, %0d timeouts",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 16,
    parameter int DRIVE_DLY    = 2
) (
    output logic clk_o,
    output logic reset_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // release reset just after a rising edge, like all other stimulus
    initial begin
        reset_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #DRIVE_DLY;
        reset_no = 1'b1;
    end

endmodule

// File: verilog.f
verilog/pss_regmap_pkg.sv
verilog/reg_bus_if.sv
verilog/axi_lite_slave.sv
verilog/pss_detector_regmap.sv
verilog/peak_statistics.sv
verilog/pss_detector_ctrl_top.sv
sim/tb_clock_gen.sv
sim/pss_detector_ctrl_tb.sv

// File: verilog/axi_lite_slave.sv
module axi_lite_slave #(
    parameter int ADDRESS_WIDTH = 11
) (
    input  logic                     clk_i,
    input  logic                     reset_ni,

    // write address channel
    input  logic [ADDRESS_WIDTH-1:0] s_axi_awaddr_i,
    input  logic                     s_axi_awvalid_i,
    output logic                     s_axi_awready_o,

    // write data channel
    input  logic [31:0]              s_axi_wdata_i,
    input  logic                     s_axi_wvalid_i,
    output logic                     s_axi_wready_o,

    // write response channel
    output logic [1:0]               s_axi_bresp_o,
    output logic                     s_axi_bvalid_o,
    input  logic                     s_axi_bready_i,

    // read address channel
    input  logic [ADDRESS_WIDTH-1:0] s_axi_araddr_i,
    input  logic                     s_axi_arvalid_i,
    output logic                     s_axi_arready_o,

    // read data channel
    output logic [31:0]              s_axi_rdata_o,
    output logic [1:0]               s_axi_rresp_o,
    output logic                     s_axi_rvalid_o,
    input  logic                     s_axi_rready_i,

    reg_bus_if.bridge                reg_if
);

    import pss_regmap_pkg::*;

    localparam int REG_ADDR_W = ADDRESS_WIDTH - 2;

    typedef enum logic [1:0] {W_IDLE, W_ACCEPT, W_ACK, W_RESP} wr_state_e;
    typedef enum logic [1:0] {R_IDLE, R_ACCEPT, R_ACK, R_RESP} rd_state_e;

    wr_state_e wr_state;
    rd_state_e rd_state;

    // strobes are ignored, every access is a full word
    assign s_axi_bresp_o = AXI_RESP_OKAY;
    assign s_axi_rresp_o = AXI_RESP_OKAY;

    // write path: accept address and data together, one request, then respond
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_state        <= W_IDLE;
            s_axi_awready_o <= 1'b0;
            s_axi_wready_o  <= 1'b0;
            s_axi_bvalid_o  <= 1'b0;
            reg_if.wreq     <= 1'b0;
        end else begin
            case (wr_state)
                W_IDLE: begin
                    if (s_axi_awvalid_i && s_axi_wvalid_i) begin
                        s_axi_awready_o <= 1'b1;
                        s_axi_wready_o  <= 1'b1;
                        wr_state        <= W_ACCEPT;
                    end
                end
                W_ACCEPT: begin
                    // handshake completes on this edge
                    s_axi_awready_o <= 1'b0;
                    s_axi_wready_o  <= 1'b0;
                    reg_if.wreq     <= 1'b1;
                    wr_state        <= W_ACK;
                end
                W_ACK: begin
                    reg_if.wreq <= 1'b0;
                    if (reg_if.wack) begin
                        s_axi_bvalid_o <= 1'b1;
                        wr_state       <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (s_axi_bready_i) begin
                        s_axi_bvalid_o <= 1'b0;
                        wr_state       <= W_IDLE;
                    end
                end
                default: wr_state <= W_IDLE;
            endcase
        end
    end

    // byte address to word index
    always_ff @(posedge clk_i) begin
        if (wr_state == W_ACCEPT) begin
            reg_if.waddr <= s_axi_awaddr_i[2 +: REG_ADDR_W];
            reg_if.wdata <= s_axi_wdata_i;
        end
    end

    // read path: one request per address, data held until rready
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rd_state        <= R_IDLE;
            s_axi_arready_o <= 1'b0;
            s_axi_rvalid_o  <= 1'b0;
            reg_if.rreq     <= 1'b0;
        end else begin
            case (rd_state)
                R_IDLE: begin
                    if (s_axi_arvalid_i) begin
                        s_axi_arready_o <= 1'b1;
                        rd_state        <= R_ACCEPT;
                    end
                end
                R_ACCEPT: begin
                    s_axi_arready_o <= 1'b0;
                    reg_if.rreq     <= 1'b1;
                    rd_state        <= R_ACK;
                end
                R_ACK: begin
                    reg_if.rreq <= 1'b0;
                    if (reg_if.rack) begin
                        s_axi_rvalid_o <= 1'b1;
                        rd_state       <= R_RESP;
                    end
                end
                R_RESP: begin
                    if (s_axi_rready_i) begin
                        s_axi_rvalid_o <= 1'b0;
                        rd_state       <= R_IDLE;
                    end
                end
                default: rd_state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_state == R_ACCEPT) begin
            reg_if.raddr <= s_axi_araddr_i[2 +: REG_ADDR_W];
        end
        // capture read data with the acknowledge
        if (rd_state == R_ACK && reg_if.rack) begin
            s_axi_rdata_o <= reg_if.rdata;
        end
    end

    a_bvalid_hold: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o
    ) else $error("bvalid dropped before bready");

    a_rdata_stable: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o)
    ) else $error("rvalid or rdata changed while waiting for rready");

endmodule

// File: verilog/peak_statistics.sv
module peak_statistics (
    input  logic                        clk_i,
    input  logic                        reset_ni,

    // peak event from the detector, single cycle
    input  logic                        peak_valid_i,
    input  logic [1:0]                  peak_nid_i,

    // software clear, wins over a peak in the same cycle
    input  logic                        clear_i,

    output pss_regmap_pkg::peak_count_t peak_count_o [pss_regmap_pkg::N_NID]
);

    import pss_regmap_pkg::*;

    // one wrapping counter per N_id
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int i = 0; i < N_NID; i++) begin
                peak_count_o[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N_NID; i++) begin
                if (clear_i) begin
                    peak_count_o[i] <= '0;
                end else if (peak_valid_i && int'(peak_nid_i) == i) begin
                    // N_id 3 never matches and is dropped
                    peak_count_o[i] <= peak_count_o[i] + 32'd1;
                end
            end
        end
    end

    a_nid_range: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        peak_valid_i |-> int'(peak_nid_i) < N_NID
    ) else $error("peak strobe with out of range N_id %0d", peak_nid_i);

endmodule

// File: verilog/pss_detector_ctrl_top.sv
module pss_detector_ctrl_top #(
    parameter int ID                        = 0,
    parameter int ADDRESS_WIDTH             = 11,
    parameter int CORR_DW                   = 32,
    parameter int VARIABLE_NOISE_LIMIT      = 1,
    parameter int VARIABLE_DETECTION_FACTOR = 1,
    parameter int INITIAL_DETECTION_SHIFT   = 3,
    parameter int INITIAL_CFO_MODE          = 0
) (
    input  logic                     clk_i,
    input  logic                     reset_ni,

    // axi-lite slave
    input  logic [ADDRESS_WIDTH-1:0] s_axi_awaddr_i,
    input  logic                     s_axi_awvalid_i,
    output logic                     s_axi_awready_o,
    input  logic [31:0]              s_axi_wdata_i,
    input  logic                     s_axi_wvalid_i,
    output logic                     s_axi_wready_o,
    output logic [1:0]               s_axi_bresp_o,
    output logic                     s_axi_bvalid_o,
    input  logic                     s_axi_bready_i,
    input  logic [ADDRESS_WIDTH-1:0] s_axi_araddr_i,
    input  logic                     s_axi_arvalid_i,
    output logic                     s_axi_arready_o,
    output logic [31:0]              s_axi_rdata_o,
    output logic [1:0]               s_axi_rresp_o,
    output logic                     s_axi_rvalid_o,
    input  logic                     s_axi_rready_i,

    // detector status
    input  logic                     peak_valid_i,
    input  logic [1:0]               peak_nid_i,
    input  logic [1:0]               mode_i,
    input  logic signed [31:0]       cfo_angle_i,
    input  logic [31:0]              peak_fifo_level_i,
    input  logic [31:0]              data_fifo_level_i,

    // detector tuning
    output logic                     cfo_mode_o,
    output logic [CORR_DW-1:0]       noise_limit_o,
    output logic [7:0]               detection_shift_o
);

    import pss_regmap_pkg::*;

    localparam int REG_ADDR_W = ADDRESS_WIDTH - 2;

    logic        cnt_clear;
    peak_count_t peak_count [N_NID];

    reg_bus_if #(.REG_ADDR_W(REG_ADDR_W)) reg_bus_i ();

    axi_lite_slave #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH)
    ) axi_lite_slave_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .s_axi_awaddr_i (s_axi_awaddr_i),
        .s_axi_awvalid_i(s_axi_awvalid_i),
        .s_axi_awready_o(s_axi_awready_o),
        .s_axi_wdata_i  (s_axi_wdata_i),
        .s_axi_wvalid_i (s_axi_wvalid_i),
        .s_axi_wready_o (s_axi_wready_o),
        .s_axi_bresp_o  (s_axi_bresp_o),
        .s_axi_bvalid_o (s_axi_bvalid_o),
        .s_axi_bready_i (s_axi_bready_i),
        .s_axi_araddr_i (s_axi_araddr_i),
        .s_axi_arvalid_i(s_axi_arvalid_i),
        .s_axi_arready_o(s_axi_arready_o),
        .s_axi_rdata_o  (s_axi_rdata_o),
        .s_axi_rresp_o  (s_axi_rresp_o),
        .s_axi_rvalid_o (s_axi_rvalid_o),
        .s_axi_rready_i (s_axi_rready_i),
        .reg_if         (reg_bus_i.bridge)
    );

    pss_detector_regmap #(
        .ID                       (ID),
        .ADDRESS_WIDTH            (ADDRESS_WIDTH),
        .CORR_DW                  (CORR_DW),
        .VARIABLE_NOISE_LIMIT     (VARIABLE_NOISE_LIMIT),
        .VARIABLE_DETECTION_FACTOR(VARIABLE_DETECTION_FACTOR),
        .INITIAL_DETECTION_SHIFT  (INITIAL_DETECTION_SHIFT),
        .INITIAL_CFO_MODE         (INITIAL_CFO_MODE)
    ) pss_detector_regmap_i (
        .clk_i            (clk_i),
        .reset_ni         (reset_ni),
        .reg_if           (reg_bus_i.regs),
        .mode_i           (mode_i),
        .cfo_angle_i      (cfo_angle_i),
        .peak_count_i     (peak_count),
        .peak_fifo_level_i(peak_fifo_level_i),
        .data_fifo_level_i(data_fifo_level_i),
        .clear_o          (cnt_clear),
        .cfo_mode_o       (cfo_mode_o),
        .noise_limit_o    (noise_limit_o),
        .detection_shift_o(detection_shift_o)
    );

    peak_statistics peak_statistics_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .peak_valid_i(peak_valid_i),
        .peak_nid_i  (peak_nid_i),
        .clear_i     (cnt_clear),
        .peak_count_o(peak_count)
    );

endmodule

// File: verilog/pss_detector_regmap.sv
module pss_detector_regmap #(
    parameter int ID                        = 0,
    parameter int ADDRESS_WIDTH             = 11,
    parameter int CORR_DW                   = 32,
    parameter int VARIABLE_NOISE_LIMIT      = 1,
    parameter int VARIABLE_DETECTION_FACTOR = 1,
    parameter int INITIAL_DETECTION_SHIFT   = 3,
    parameter int INITIAL_CFO_MODE          = 0
) (
    input  logic                       clk_i,
    input  logic                       reset_ni,

    reg_bus_if.regs                    reg_if,

    // live detector status
    input  logic [1:0]                 mode_i,
    input  logic signed [31:0]         cfo_angle_i,
    input  pss_regmap_pkg::peak_count_t peak_count_i [pss_regmap_pkg::N_NID],
    input  logic [31:0]                peak_fifo_level_i,
    input  logic [31:0]                data_fifo_level_i,

    // to the statistics block
    output logic                       clear_o,

    // tuning outputs
    output logic                       cfo_mode_o,
    output logic [CORR_DW-1:0]         noise_limit_o,
    output logic [7:0]                 detection_shift_o
);

    import pss_regmap_pkg::*;

    localparam int REG_ADDR_W = ADDRESS_WIDTH - 2;
    localparam logic [CORR_DW-1:0] INITIAL_NOISE_LIMIT =
        {{(CORR_DW - 1){1'b0}}, 1'b1} << (CORR_DW / 2);

    logic [31:0] scratch;

    // acknowledges, scratch, cfo mode and the counter clear strobe
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            reg_if.wack <= 1'b0;
            reg_if.rack <= 1'b0;
            clear_o     <= 1'b0;
            cfo_mode_o  <= 1'(INITIAL_CFO_MODE);
            scratch     <= '0;
        end else begin
            reg_if.wack <= reg_if.wreq;
            reg_if.rack <= reg_if.rreq;
            clear_o     <= reg_if.wreq && (int'(reg_if.waddr) == REG_CNT_CLEAR);
            if (reg_if.wreq && int'(reg_if.waddr) == REG_CFO_MODE) begin
                cfo_mode_o <= reg_if.wdata[0];
            end
            if (reg_if.wreq && int'(reg_if.waddr) == REG_SCRATCH) begin
                scratch <= reg_if.wdata;
            end
        end
    end

    // noise limit is writable only in the variable build
    if (VARIABLE_NOISE_LIMIT != 0) begin : g_noise_var
        always_ff @(posedge clk_i) begin
            if (!reset_ni) begin
                noise_limit_o <= INITIAL_NOISE_LIMIT;
            end else if (reg_if.wreq && int'(reg_if.waddr) == REG_NOISE_LIMIT) begin
                noise_limit_o <= CORR_DW'(reg_if.wdata);
            end
        end
    end else begin : g_noise_fixed
        assign noise_limit_o = INITIAL_NOISE_LIMIT;
    end

    if (VARIABLE_DETECTION_FACTOR != 0) begin : g_shift_var
        always_ff @(posedge clk_i) begin
            if (!reset_ni) begin
                detection_shift_o <= 8'(INITIAL_DETECTION_SHIFT);
            end else if (reg_if.wreq && int'(reg_if.waddr) == REG_DET_SHIFT) begin
                // only the low byte is kept
                detection_shift_o <= reg_if.wdata[7:0];
            end
        end
    end else begin : g_shift_fixed
        assign detection_shift_o = 8'(INITIAL_DETECTION_SHIFT);
    end

    // registered read mux, valid together with rack
    always_ff @(posedge clk_i) begin
        if (reg_if.rreq) begin
            case (int'(reg_if.raddr))
                REG_VERSION:       reg_if.rdata <= PCORE_VERSION;
                REG_ID:            reg_if.rdata <= 32'(ID);
                REG_SCRATCH:       reg_if.rdata <= scratch;
                REG_MAGIC:         reg_if.rdata <= PSSD_MAGIC;
                REG_FILLER:        reg_if.rdata <= FILLER_WORD;
                REG_MODE:          reg_if.rdata <= 32'(mode_i);
                REG_CFO_ANGLE:     reg_if.rdata <= cfo_angle_i;
                REG_CFO_MODE:      reg_if.rdata <= 32'(cfo_mode_o);
                REG_PEAK_CNT_0:    reg_if.rdata <= peak_count_i[0];
                REG_PEAK_CNT_1:    reg_if.rdata <= peak_count_i[1];
                REG_PEAK_CNT_2:    reg_if.rdata <= peak_count_i[2];
                REG_NOISE_LIMIT:   reg_if.rdata <= 32'(noise_limit_o);
                REG_DET_SHIFT:     reg_if.rdata <= 32'(detection_shift_o);
                REG_PEAK_FIFO_LVL: reg_if.rdata <= peak_fifo_level_i;
                REG_DATA_FIFO_LVL: reg_if.rdata <= data_fifo_level_i;
                // unmapped and the clear register
                default:           reg_if.rdata <= '0;
            endcase
        end
    end

    // a write request is a single strobe, answered in the next cycle
    a_wack_follows_wreq: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        reg_if.wreq |=> reg_if.wack && !reg_if.wreq
    ) else $error("wreq is not a single strobe answered by wack one cycle later");

endmodule

// File: verilog/pss_regmap_pkg.sv
package pss_regmap_pkg;

    // identification words
    localparam logic [31:0] PCORE_VERSION = 32'h0004_0069;
    // ascii "PSSD"
    localparam logic [31:0] PSSD_MAGIC    = 32'h5053_5344;
    localparam logic [31:0] FILLER_WORD   = 32'h6969_6969;

    // register word indices
    localparam int REG_VERSION       = 0;
    localparam int REG_ID            = 1;
    localparam int REG_SCRATCH       = 2;
    localparam int REG_MAGIC         = 3;
    localparam int REG_FILLER        = 4;
    localparam int REG_MODE          = 5;
    localparam int REG_CFO_ANGLE     = 6;
    localparam int REG_CFO_MODE      = 7;
    localparam int REG_PEAK_CNT_0    = 8;
    localparam int REG_PEAK_CNT_1    = 9;
    localparam int REG_PEAK_CNT_2    = 10;
    localparam int REG_NOISE_LIMIT   = 11;
    localparam int REG_DET_SHIFT     = 12;
    localparam int REG_PEAK_FIFO_LVL = 13;
    localparam int REG_DATA_FIFO_LVL = 14;
    // write only, reads back as zero
    localparam int REG_CNT_CLEAR     = 15;

    // axi response codes
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // one counter per N_id
    localparam int N_NID = 3;

    typedef logic [31:0] peak_count_t;

endpackage

// File: verilog/reg_bus_if.sv
interface reg_bus_if #(
    parameter int REG_ADDR_W = 9
);

    // write request and acknowledge
    logic                  wreq;
    logic [REG_ADDR_W-1:0] waddr;
    logic [31:0]           wdata;
    logic                  wack;

    // read request and acknowledge
    logic                  rreq;
    logic [REG_ADDR_W-1:0] raddr;
    logic [31:0]           rdata;
    logic                  rack;

    // axi side, issues requests
    modport bridge (
        output wreq, waddr, wdata, rreq, raddr,
        input  wack, rack, rdata
    );

    // register file side, answers requests
    modport regs (
        input  wreq, waddr, wdata, rreq, raddr,
        output wack, rack, rdata
    );

endinterface
